//--- verilog/mmu_pkg.sv
// ==============================
// MMU shared definitions
// Address widths, PTE layout, enums
// ==============================

package mmu_pkg;

  // Address geometry
  localparam int vaddr_width       = 16;
  localparam int paddr_width       = 12;
  localparam int page_offset_width = 8;
  localparam int vpn_level_width   = 4;
  localparam int ppn_width         = 4;
  localparam int vtag_width        = 2 * vpn_level_width;

  // Data path and RAM
  localparam int word_width     = 32;
  localparam int ram_addr_width = 10;
  localparam int ram_depth      = 2 ** ram_addr_width;
  // Word index of a PTE inside its table page
  localparam int pte_idx_width  = ram_addr_width - ppn_width;

  // TLB
  localparam int tlb_entries   = 4;
  localparam int tlb_idx_width = $clog2(tlb_entries);

  // PTE bit positions
  localparam int pte_v_bit   = 0;
  localparam int pte_r_bit   = 1;
  localparam int pte_w_bit   = 2;
  localparam int pte_x_bit   = 3;
  localparam int pte_u_bit   = 4;
  localparam int pte_d_bit   = 7;
  localparam int pte_ppn_lsb = 10;

  typedef enum logic {
    e_load,
    e_store
  } mem_op_e;

  typedef enum logic {
    e_priv_u,
    e_priv_s
  } priv_e;

  typedef enum logic [1:0] {
    e_walk_idle,
    e_walk_l1,
    e_walk_l0
  } walk_state_e;

endpackage

//--- verilog/data_ram.sv
// ==============================
// Data RAM, 1024 words
// Synchronous read, shared port
// ==============================
`timescale 1ns/1ps

module data_ram (
  input  logic                                clk_i,
  input  logic                                en_i,
  input  logic                                we_i,
  input  logic [mmu_pkg::ram_addr_width-1:0]  addr_i,
  input  logic [mmu_pkg::word_width-1:0]      wdata_i,
  output logic [mmu_pkg::word_width-1:0]      rdata_o
);

  logic [mmu_pkg::word_width-1:0] mem_r [mmu_pkg::ram_depth];

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_r[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_r[addr_i];
      end
    end
  end

endmodule

//--- verilog/dtlb.sv
// ==============================
// Data TLB, fully associative
// Registered lookup, round-robin fill
// ==============================
`timescale 1ns/1ps

module dtlb (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              flush_i,
  input  logic                              lookup_v_i,
  input  logic [mmu_pkg::vtag_width-1:0]    lookup_vtag_i,
  input  logic                              fill_v_i,
  input  logic [mmu_pkg::vtag_width-1:0]    fill_vtag_i,
  input  logic [mmu_pkg::ppn_width-1:0]     fill_ppn_i,
  input  logic                              fill_u_i,
  input  logic                              fill_w_i,
  input  logic                              fill_d_i,
  output logic                              hit_o,
  output logic                              miss_o,
  output logic [mmu_pkg::ppn_width-1:0]     ppn_o,
  output logic                              u_o,
  output logic                              w_o,
  output logic                              d_o
);

  logic [mmu_pkg::tlb_entries-1:0]   valid_r;
  logic [mmu_pkg::vtag_width-1:0]    tag_r [mmu_pkg::tlb_entries];
  logic [mmu_pkg::ppn_width-1:0]     ppn_r [mmu_pkg::tlb_entries];
  logic [mmu_pkg::tlb_entries-1:0]   u_r;
  logic [mmu_pkg::tlb_entries-1:0]   w_r;
  logic [mmu_pkg::tlb_entries-1:0]   d_r;
  logic [mmu_pkg::tlb_idx_width-1:0] fill_ptr_r;

  logic [mmu_pkg::tlb_entries-1:0]   match;
  logic                              bypass;
  logic                              hit;
  logic [mmu_pkg::ppn_width-1:0]     sel_ppn;
  logic                              sel_u;
  logic                              sel_w;
  logic                              sel_d;

  always_comb begin
    sel_ppn = '0;
    sel_u   = 1'b0;
    sel_w   = 1'b0;
    sel_d   = 1'b0;
    for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
      match[i] = valid_r[i] & (tag_r[i] == lookup_vtag_i);
      if (match[i]) begin
        sel_ppn = ppn_r[i];
        sel_u   = u_r[i];
        sel_w   = w_r[i];
        sel_d   = d_r[i];
      end
    end
    // A fill in the same cycle is visible to the lookup
    bypass = fill_v_i & (fill_vtag_i == lookup_vtag_i);
    if (bypass) begin
      sel_ppn = fill_ppn_i;
      sel_u   = fill_u_i;
      sel_w   = fill_w_i;
      sel_d   = fill_d_i;
    end
    hit = bypass | (|match);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r    <= '0;
      fill_ptr_r <= '0;
      hit_o      <= 1'b0;
      miss_o     <= 1'b0;
    end else begin
      hit_o  <= lookup_v_i & hit;
      miss_o <= lookup_v_i & ~hit;
      if (flush_i) begin
        valid_r <= '0;
      end else if (fill_v_i) begin
        valid_r[fill_ptr_r] <= 1'b1;
        fill_ptr_r          <= fill_ptr_r + 1'b1;
      end
    end
  end

  // Entry payload and lookup fields
  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_ptr_r] <= fill_vtag_i;
      ppn_r[fill_ptr_r] <= fill_ppn_i;
      u_r[fill_ptr_r]   <= fill_u_i;
      w_r[fill_ptr_r]   <= fill_w_i;
      d_r[fill_ptr_r]   <= fill_d_i;
    end
    ppn_o <= sel_ppn;
    u_o   <= sel_u;
    w_o   <= sel_w;
    d_o   <= sel_d;
  end

endmodule

//--- verilog/page_walker.sv
// ==============================
// Two-level page table walker
// Fills the TLB or flags a page fault
// ==============================
`timescale 1ns/1ps

module page_walker (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                start_i,
  input  logic [mmu_pkg::vaddr_width-1:0]     start_vaddr_i,
  input  logic                                start_store_i,
  input  logic [mmu_pkg::ppn_width-1:0]       base_ppn_i,
  input  logic [mmu_pkg::word_width-1:0]      ram_rdata_i,
  output logic                                ram_rd_o,
  output logic [mmu_pkg::ram_addr_width-1:0]  ram_addr_o,
  output logic                                busy_o,
  output logic                                fill_v_o,
  output logic [mmu_pkg::vtag_width-1:0]      fill_vtag_o,
  output logic [mmu_pkg::ppn_width-1:0]       fill_ppn_o,
  output logic                                fill_u_o,
  output logic                                fill_w_o,
  output logic                                fill_d_o,
  output logic                                fault_v_o,
  output logic [mmu_pkg::vaddr_width-1:0]     fault_vaddr_o,
  output logic                                fault_store_o
);

  mmu_pkg::walk_state_e                   state_r;
  logic                                   wait_r;
  logic                                   fill_v_r;
  logic                                   fault_v_r;
  logic [mmu_pkg::vaddr_width-1:0]        vaddr_r;
  logic                                   store_r;
  logic [mmu_pkg::ppn_width-1:0]          table_ppn_r;
  logic [mmu_pkg::ppn_width-1:0]          leaf_ppn_r;
  logic                                   leaf_u_r;
  logic                                   leaf_w_r;
  logic                                   leaf_d_r;

  logic [mmu_pkg::vpn_level_width-1:0]    vpn_sel;
  logic [mmu_pkg::pte_idx_width-1:0]      pte_idx;
  logic [mmu_pkg::ppn_width-1:0]          pte_ppn;
  logic                                   pte_valid;
  logic                                   l1_fault;

  assign pte_ppn   = ram_rdata_i[mmu_pkg::pte_ppn_lsb +: mmu_pkg::ppn_width];
  assign pte_valid = ram_rdata_i[mmu_pkg::pte_v_bit];
  // Leaf bits at level 1 mean a superpage, which is not supported
  assign l1_fault  = ~pte_valid | ram_rdata_i[mmu_pkg::pte_r_bit]
                   | ram_rdata_i[mmu_pkg::pte_w_bit] | ram_rdata_i[mmu_pkg::pte_x_bit];

  // PTE address is the table page plus the VPN field of this level
  assign vpn_sel = (state_r == mmu_pkg::e_walk_l1)
                 ? vaddr_r[mmu_pkg::vaddr_width-1 -: mmu_pkg::vpn_level_width]
                 : vaddr_r[mmu_pkg::page_offset_width +: mmu_pkg::vpn_level_width];
  assign pte_idx = {{(mmu_pkg::pte_idx_width - mmu_pkg::vpn_level_width){1'b0}}, vpn_sel};

  assign ram_addr_o = {table_ppn_r, pte_idx};
  assign ram_rd_o   = (state_r != mmu_pkg::e_walk_idle) & ~wait_r;
  assign busy_o     = (state_r != mmu_pkg::e_walk_idle);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= mmu_pkg::e_walk_idle;
      wait_r    <= 1'b0;
      fill_v_r  <= 1'b0;
      fault_v_r <= 1'b0;
    end else begin
      fill_v_r  <= 1'b0;
      fault_v_r <= 1'b0;
      case (state_r)
        mmu_pkg::e_walk_idle: begin
          if (start_i) begin
            state_r <= mmu_pkg::e_walk_l1;
            wait_r  <= 1'b0;
          end
        end
        mmu_pkg::e_walk_l1: begin
          if (!wait_r) begin
            wait_r <= 1'b1;
          end else if (l1_fault) begin
            fault_v_r <= 1'b1;
            state_r   <= mmu_pkg::e_walk_idle;
          end else begin
            state_r <= mmu_pkg::e_walk_l0;
            wait_r  <= 1'b0;
          end
        end
        mmu_pkg::e_walk_l0: begin
          if (!wait_r) begin
            wait_r <= 1'b1;
          end else begin
            fault_v_r <= ~pte_valid;
            fill_v_r  <= pte_valid;
            state_r   <= mmu_pkg::e_walk_idle;
          end
        end
        default: state_r <= mmu_pkg::e_walk_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == mmu_pkg::e_walk_idle) && start_i) begin
      vaddr_r     <= start_vaddr_i;
      store_r     <= start_store_i;
      table_ppn_r <= base_ppn_i;
    end else if ((state_r == mmu_pkg::e_walk_l1) && wait_r) begin
      table_ppn_r <= pte_ppn;
    end
    if ((state_r == mmu_pkg::e_walk_l0) && wait_r) begin
      leaf_ppn_r <= pte_ppn;
      leaf_u_r   <= ram_rdata_i[mmu_pkg::pte_u_bit];
      leaf_w_r   <= ram_rdata_i[mmu_pkg::pte_w_bit];
      leaf_d_r   <= ram_rdata_i[mmu_pkg::pte_d_bit];
    end
  end

  // Results come out in the first idle cycle
  assign fill_v_o      = fill_v_r;
  assign fill_vtag_o   = vaddr_r[mmu_pkg::vaddr_width-1 -: mmu_pkg::vtag_width];
  assign fill_ppn_o    = leaf_ppn_r;
  assign fill_u_o      = leaf_u_r;
  assign fill_w_o      = leaf_w_r;
  assign fill_d_o      = leaf_d_r;
  assign fault_v_o     = fault_v_r;
  assign fault_vaddr_o = vaddr_r;
  assign fault_store_o = store_r;

endmodule

//--- verilog/mmu_top.sv
// ==============================
// Data MMU top
// Two-stage command pipe, TLB and walker
// ==============================
`timescale 1ns/1ps

module mmu_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                cmd_v_i,
  input  mmu_pkg::mem_op_e                    cmd_op_i,
  input  logic [mmu_pkg::vaddr_width-1:0]     cmd_vaddr_i,
  input  logic [mmu_pkg::word_width-1:0]      cmd_data_i,
  output logic                                cmd_ready_o,
  input  logic                                translation_en_i,
  input  mmu_pkg::priv_e                      priv_mode_i,
  input  logic                                sum_i,
  input  logic [mmu_pkg::ppn_width-1:0]       satp_ppn_i,
  input  logic                                flush_i,
  output logic                                resp_v_o,
  output logic [mmu_pkg::word_width-1:0]      resp_data_o,
  output logic                                resp_miss_o,
  output logic                                resp_access_fault_o,
  output logic                                fault_v_o,
  output logic [mmu_pkg::vaddr_width-1:0]     fault_vaddr_o,
  output logic                                fault_store_o
);

  logic                               cmd_accept;
  logic                               s1_v_r;
  mmu_pkg::mem_op_e                   s1_op_r;
  logic [mmu_pkg::vaddr_width-1:0]    s1_vaddr_r;
  logic [mmu_pkg::word_width-1:0]     s1_data_r;
  logic                               s1_xlate_r;

  logic                               tlb_hit;
  logic                               tlb_miss;
  logic [mmu_pkg::ppn_width-1:0]      tlb_ppn;
  logic                               tlb_u;
  logic                               tlb_w;
  logic                               tlb_d;

  logic                               walk_busy;
  logic                               walk_rd;
  logic [mmu_pkg::ram_addr_width-1:0] walk_addr;
  logic                               fill_v;
  logic [mmu_pkg::vtag_width-1:0]     fill_vtag;
  logic [mmu_pkg::ppn_width-1:0]      fill_ppn;
  logic                               fill_u;
  logic                               fill_w;
  logic                               fill_d;

  logic                               s1_store;
  logic                               s1_miss;
  logic                               priv_fault;
  logic                               write_fault;
  logic                               s1_access_fault;
  logic                               s1_go;
  logic [mmu_pkg::paddr_width-1:0]    s1_paddr;

  logic                               ram_en;
  logic                               ram_we;
  logic [mmu_pkg::ram_addr_width-1:0] ram_addr;
  logic [mmu_pkg::word_width-1:0]     ram_rdata;

  logic                               s2_v_r;
  logic                               s2_miss_r;
  logic                               s2_fault_r;
  logic                               s2_load_r;

  // Hold off commands until a miss has been walked
  assign cmd_ready_o = ~s1_miss & ~walk_busy;
  assign cmd_accept  = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= cmd_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      s1_op_r    <= cmd_op_i;
      s1_vaddr_r <= cmd_vaddr_i;
      s1_data_r  <= cmd_data_i;
      s1_xlate_r <= translation_en_i;
    end
  end

  dtlb tlb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .lookup_v_i    (cmd_accept & translation_en_i),
    .lookup_vtag_i (cmd_vaddr_i[mmu_pkg::vaddr_width-1 -: mmu_pkg::vtag_width]),
    .fill_v_i      (fill_v),
    .fill_vtag_i   (fill_vtag),
    .fill_ppn_i    (fill_ppn),
    .fill_u_i      (fill_u),
    .fill_w_i      (fill_w),
    .fill_d_i      (fill_d),
    .hit_o         (tlb_hit),
    .miss_o        (tlb_miss),
    .ppn_o         (tlb_ppn),
    .u_o           (tlb_u),
    .w_o           (tlb_w),
    .d_o           (tlb_d)
  );

  // Stage 1 permission check
  assign s1_store    = (s1_op_r == mmu_pkg::e_store);
  assign s1_miss     = s1_v_r & s1_xlate_r & tlb_miss;
  assign priv_fault  = ((priv_mode_i == mmu_pkg::e_priv_s) & ~sum_i & tlb_u)
                     | ((priv_mode_i == mmu_pkg::e_priv_u) & ~tlb_u);
  assign write_fault = s1_store & (~tlb_w | ~tlb_d);
  assign s1_access_fault = s1_v_r & s1_xlate_r & tlb_hit & (priv_fault | write_fault);
  assign s1_go       = s1_v_r & ~s1_miss & ~s1_access_fault;

  // Bare mode uses the low address bits directly
  assign s1_paddr = s1_xlate_r
                  ? {tlb_ppn, s1_vaddr_r[mmu_pkg::page_offset_width-1:0]}
                  : s1_vaddr_r[mmu_pkg::paddr_width-1:0];

  page_walker walker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (s1_miss),
    .start_vaddr_i (s1_vaddr_r),
    .start_store_i (s1_store),
    .base_ppn_i    (satp_ppn_i),
    .ram_rdata_i   (ram_rdata),
    .ram_rd_o      (walk_rd),
    .ram_addr_o    (walk_addr),
    .busy_o        (walk_busy),
    .fill_v_o      (fill_v),
    .fill_vtag_o   (fill_vtag),
    .fill_ppn_o    (fill_ppn),
    .fill_u_o      (fill_u),
    .fill_w_o      (fill_w),
    .fill_d_o      (fill_d),
    .fault_v_o     (fault_v_o),
    .fault_vaddr_o (fault_vaddr_o),
    .fault_store_o (fault_store_o)
  );

  // Walker owns the RAM port while busy
  assign ram_en   = walk_busy ? walk_rd : s1_go;
  assign ram_we   = ~walk_busy & s1_go & s1_store;
  assign ram_addr = walk_busy ? walk_addr
                  : s1_paddr[mmu_pkg::paddr_width-1 -: mmu_pkg::ram_addr_width];

  data_ram ram (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (s1_data_r),
    .rdata_o (ram_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_v_r     <= 1'b0;
      s2_miss_r  <= 1'b0;
      s2_fault_r <= 1'b0;
      s2_load_r  <= 1'b0;
    end else begin
      s2_v_r     <= s1_v_r;
      s2_miss_r  <= s1_miss;
      s2_fault_r <= s1_access_fault;
      s2_load_r  <= s1_go & ~s1_store;
    end
  end

  assign resp_v_o            = s2_v_r;
  assign resp_miss_o         = s2_miss_r;
  assign resp_access_fault_o = s2_fault_r;
  // Only a completed load carries data
  assign resp_data_o         = s2_load_r ? ram_rdata : '0;

endmodule

//--- dv/mmu_tb.sv
// ==============================
// MMU testbench
// Random commands against a model
// ==============================
`timescale 1ns/1ps

module mmu_tb;

  logic                                clk_i;
  logic                                reset_i;
  logic                                cmd_v_i;
  mmu_pkg::mem_op_e                    cmd_op_i;
  logic [mmu_pkg::vaddr_width-1:0]     cmd_vaddr_i;
  logic [mmu_pkg::word_width-1:0]      cmd_data_i;
  logic                                cmd_ready_o;
  logic                                translation_en_i;
  mmu_pkg::priv_e                      priv_mode_i;
  logic                                sum_i;
  logic [mmu_pkg::ppn_width-1:0]       satp_ppn_i;
  logic                                flush_i;
  logic                                resp_v_o;
  logic [mmu_pkg::word_width-1:0]      resp_data_o;
  logic                                resp_miss_o;
  logic                                resp_access_fault_o;
  logic                                fault_v_o;
  logic [mmu_pkg::vaddr_width-1:0]     fault_vaddr_o;
  logic                                fault_store_o;

  // Reference model state
  logic [mmu_pkg::word_width-1:0]      model_mem [mmu_pkg::ram_depth];
  logic                                tlb_v     [mmu_pkg::tlb_entries];
  logic [mmu_pkg::vtag_width-1:0]      tlb_tag   [mmu_pkg::tlb_entries];
  logic [mmu_pkg::ppn_width-1:0]       tlb_ppn   [mmu_pkg::tlb_entries];
  logic                                tlb_u     [mmu_pkg::tlb_entries];
  logic                                tlb_w     [mmu_pkg::tlb_entries];
  logic                                tlb_d     [mmu_pkg::tlb_entries];
  int                                  tlb_ptr;

  int                                  exp_due_q  [$];
  logic                                exp_miss_q [$];
  logic                                exp_af_q   [$];
  logic [mmu_pkg::word_width-1:0]      exp_data_q [$];
  logic                                fault_pending;
  logic [mmu_pkg::vaddr_width-1:0]     fault_exp_vaddr;
  mmu_pkg::mem_op_e                    fault_exp_op;
  int                                  cycle_count;
  int                                  issued;

  mmu_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at time %0t: %s", $time, why);
    stop_with_failure();
  endtask

  task automatic check_data(input logic [mmu_pkg::word_width-1:0] got,
                            input logic [mmu_pkg::word_width-1:0] exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  task automatic check_fault(input logic [mmu_pkg::vaddr_width-1:0] got_va,
                             input logic [mmu_pkg::vaddr_width-1:0] exp_va,
                             input mmu_pkg::mem_op_e got_op, input mmu_pkg::mem_op_e exp_op);
    if ((got_va !== exp_va) || (got_op !== exp_op)) begin
      report_mismatch($sformatf("page fault got %h %s expected %h %s",
                                got_va, got_op.name(), exp_va, exp_op.name()));
    end
  endtask

  task automatic sample_outputs();
    if (resp_v_o) begin
      if (exp_due_q.size() == 0) begin
        abort_run("response arrived with no command in flight");
      end else if (exp_due_q[0] != cycle_count) begin
        abort_run("response arrived at the wrong cycle");
      end else begin
        check_flag(resp_miss_o, exp_miss_q[0], "resp miss");
        check_flag(resp_access_fault_o, exp_af_q[0], "resp access fault");
        check_data(resp_data_o, exp_data_q[0], "resp data");
        void'(exp_due_q.pop_front());
        void'(exp_miss_q.pop_front());
        void'(exp_af_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end else if ((exp_due_q.size() != 0) && (exp_due_q[0] <= cycle_count)) begin
      abort_run("expected response did not arrive");
    end
    if (fault_v_o) begin
      if (!fault_pending) begin
        abort_run("page fault pulse without a failing walk");
      end else begin
        check_fault(fault_vaddr_o, fault_exp_vaddr,
                    fault_store_o ? mmu_pkg::e_store : mmu_pkg::e_load, fault_exp_op);
        // Walk end and fault pulse share a cycle
        check_flag(cmd_ready_o, 1'b1, "ready with page fault");
        fault_pending = 1'b0;
      end
    end
  endtask

  // Advance one cycle and drop the strobes after sampling
  task automatic tick();
    mmu_pkg::walk_state_e ws;
    @(negedge clk_i);
    cycle_count++;
    if (cycle_count > 200 * issued + 1000) begin
      ws = UUT.walker.state_r;
      abort_run($sformatf("run did not finish, walker state %s", ws.name()));
    end
    sample_outputs();
    cmd_v_i = 1'b0;
    flush_i = 1'b0;
  endtask

  task automatic drain();
    while ((exp_due_q.size() != 0) || fault_pending) begin
      tick();
    end
  endtask

  task automatic flush_tlb();
    flush_i = 1'b1;
    for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
      tlb_v[i] = 1'b0;
    end
    tick();
  endtask

  function automatic int tlb_find(input logic [mmu_pkg::vtag_width-1:0] tag);
    int slot;
    slot = -1;
    for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
      if (tlb_v[i] && (tlb_tag[i] == tag)) slot = i;
    end
    return slot;
  endfunction

  // Two-level walk over the model memory
  function automatic logic walk_model(input logic [mmu_pkg::vaddr_width-1:0] va,
                                      output logic [mmu_pkg::ppn_width-1:0] ppn,
                                      output logic u, output logic w, output logic d);
    logic [mmu_pkg::word_width-1:0] pte;
    ppn = '0;
    u   = 1'b0;
    w   = 1'b0;
    d   = 1'b0;
    pte = model_mem[{satp_ppn_i, 2'b00, va[15:12]}];
    if (!pte[mmu_pkg::pte_v_bit] || pte[mmu_pkg::pte_r_bit] || pte[mmu_pkg::pte_w_bit]
        || pte[mmu_pkg::pte_x_bit]) return 1'b0;
    pte = model_mem[{pte[13:10], 2'b00, va[11:8]}];
    if (!pte[mmu_pkg::pte_v_bit]) return 1'b0;
    ppn = pte[13:10];
    u   = pte[mmu_pkg::pte_u_bit];
    w   = pte[mmu_pkg::pte_w_bit];
    d   = pte[mmu_pkg::pte_d_bit];
    return 1'b1;
  endfunction

  function automatic logic [mmu_pkg::vaddr_width-1:0] word_vaddr(input int page, input int idx);
    logic [mmu_pkg::vaddr_width-1:0] va;
    va       = '0;
    va[11:8] = page;
    va[5:2]  = idx;
    return va;
  endfunction

  // Lands on words 0..7 of a page
  function automatic logic [mmu_pkg::vaddr_width-1:0] rand_vaddr(input logic bare);
    logic [mmu_pkg::vaddr_width-1:0] va;
    va      = $urandom;
    va[7:5] = 3'b000;
    va[1:0] = 2'b00;
    if (bare) va[11:8] = 4 + $urandom % 12;
    return va;
  endfunction

  function automatic mmu_pkg::mem_op_e rand_op();
    return ($urandom % 2) ? mmu_pkg::e_store : mmu_pkg::e_load;
  endfunction

  task automatic send_cmd(input mmu_pkg::mem_op_e op, input logic [15:0] va,
                          input logic [31:0] wd, input logic miss, input logic af,
                          input logic [31:0] rd);
    cmd_v_i     = 1'b1;
    cmd_op_i    = op;
    cmd_vaddr_i = va;
    cmd_data_i  = wd;
    exp_due_q.push_back(cycle_count + 2);
    exp_miss_q.push_back(miss);
    exp_af_q.push_back(af);
    exp_data_q.push_back(rd);
    issued++;
    tick();
  endtask

  task automatic access(input mmu_pkg::mem_op_e op, input logic [15:0] va,
                        input logic [31:0] wd);
    int                              slot;
    logic                            walk_ok;
    logic                            af;
    logic [mmu_pkg::ppn_width-1:0]   ppn;
    logic                            u;
    logic                            w;
    logic                            d;
    logic [mmu_pkg::word_width-1:0]  rd;
    logic [mmu_pkg::ram_addr_width-1:0] widx;
    while (!cmd_ready_o) tick();
    rd = '0;
    if (!translation_en_i) begin
      widx = va[11:2];
      if (op == mmu_pkg::e_store) model_mem[widx] = wd;
      else rd = model_mem[widx];
      send_cmd(op, va, wd, 1'b0, 1'b0, rd);
      return;
    end
    slot = tlb_find(va[15:8]);
    if (slot < 0) begin
      walk_ok = walk_model(va, ppn, u, w, d);
      if (!walk_ok) begin
        fault_pending   = 1'b1;
        fault_exp_vaddr = va;
        fault_exp_op    = op;
      end
      send_cmd(op, va, wd, 1'b1, 1'b0, '0);
      while (!cmd_ready_o) tick();
      if (fault_pending) abort_run("walk ended without the expected page fault");
      // A faulted command is dropped, not replayed
      if (!walk_ok) return;
      slot          = tlb_ptr;
      tlb_v[slot]   = 1'b1;
      tlb_tag[slot] = va[15:8];
      tlb_ppn[slot] = ppn;
      tlb_u[slot]   = u;
      tlb_w[slot]   = w;
      tlb_d[slot]   = d;
      tlb_ptr       = (tlb_ptr + 1) % mmu_pkg::tlb_entries;
    end
    af = ((priv_mode_i == mmu_pkg::e_priv_s) && !sum_i && tlb_u[slot])
       || ((priv_mode_i == mmu_pkg::e_priv_u) && !tlb_u[slot])
       || ((op == mmu_pkg::e_store) && (!tlb_w[slot] || !tlb_d[slot]));
    widx = {tlb_ppn[slot], va[7:2]};
    if (!af && (op == mmu_pkg::e_store)) model_mem[widx] = wd;
    else if (!af) rd = model_mem[widx];
    send_cmd(op, va, wd, 1'b0, af, rd);
  endtask

  task automatic find_mapped(output logic [mmu_pkg::vaddr_width-1:0] va);
    logic [mmu_pkg::ppn_width-1:0] ppn;
    logic                          u;
    logic                          w;
    logic                          d;
    for (int i = 0; i < 1000; i++) begin
      va = rand_vaddr(1'b0);
      if (walk_model(va, ppn, u, w, d)) return;
    end
    abort_run("no mapped page found in the page tables");
  endtask

  initial begin
    logic [mmu_pkg::word_width-1:0]  pte;
    logic [mmu_pkg::vaddr_width-1:0] va;
    logic [mmu_pkg::vaddr_width-1:0] hot_va;
    int                              kind;
    void'($urandom(32'h5439_9ed3));
    reset_i          = 1'b1;
    cmd_v_i          = 1'b0;
    cmd_op_i         = mmu_pkg::e_load;
    cmd_vaddr_i      = '0;
    cmd_data_i       = '0;
    translation_en_i = 1'b0;
    priv_mode_i      = mmu_pkg::e_priv_s;
    sum_i            = 1'b1;
    satp_ppn_i       = '0;
    flush_i          = 1'b0;
    cycle_count      = 0;
    issued           = 0;
    fault_pending    = 1'b0;
    tlb_ptr          = 0;
    for (int i = 0; i < mmu_pkg::tlb_entries; i++) tlb_v[i] = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    tick();
    check_flag(cmd_ready_o, 1'b1, "ready after reset");
    check_flag(resp_v_o, 1'b0, "resp valid after reset");
    check_flag(fault_v_o, 1'b0, "fault valid after reset");

    // Bare mode with the level-1 table in page 0
    for (int i = 0; i < 16; i++) begin
      kind = (i < 3) ? i : $urandom % 8;
      if (kind == 0) begin
        pte = $urandom & 32'hffff_fffe;
      end else if (kind == 1) begin
        pte = ($urandom & 32'hffff_fff0) | 32'h1 | (32'h2 << ($urandom % 3));
      end else begin
        pte        = 32'h1;
        pte[13:10] = 1 + i % 3;
      end
      access(mmu_pkg::e_store, word_vaddr(0, i), pte);
    end
    // Level-0 tables in pages 1 to 3 with entry 0 of page 3 invalid
    for (int pg = 1; pg < 4; pg++) begin
      for (int i = 0; i < 16; i++) begin
        pte        = $urandom;
        pte[0]     = !(((pg == 3) && (i == 0)) || ($urandom % 8 == 0));
        pte[1]     = 1'b1;
        pte[3]     = 1'b0;
        pte[13:10] = 4 + $urandom % 12;
        access(mmu_pkg::e_store, word_vaddr(pg, i), pte);
      end
    end
    for (int pg = 4; pg < 16; pg++) begin
      for (int i = 0; i < 8; i++) access(mmu_pkg::e_store, word_vaddr(pg, i), $urandom);
    end
    repeat (64) access(rand_op(), rand_vaddr(1'b1), $urandom);

    // Miss, walk and replay
    drain();
    translation_en_i = 1'b1;
    repeat (6) begin
      find_mapped(va);
      access(mmu_pkg::e_store, va, $urandom);
      access(mmu_pkg::e_load, va, '0);
    end

    // Page faults at each level
    access(mmu_pkg::e_load, 16'h0010, '0);
    access(mmu_pkg::e_store, 16'h1004, $urandom);
    access(mmu_pkg::e_load, 16'h2008, '0);
    repeat (40) access(rand_op(), rand_vaddr(1'b0), $urandom);

    // Access faults over privilege settings
    repeat (120) begin
      drain();
      priv_mode_i = ($urandom % 2) ? mmu_pkg::e_priv_s : mmu_pkg::e_priv_u;
      sum_i       = $urandom;
      access(rand_op(), rand_vaddr(1'b0), $urandom);
    end
    drain();
    translation_en_i = 1'b0;
    priv_mode_i      = mmu_pkg::e_priv_s;
    sum_i            = 1'b1;
    for (int pg = 4; pg < 16; pg++) begin
      for (int i = 0; i < 8; i++) access(mmu_pkg::e_load, word_vaddr(pg, i), '0);
    end

    // Pipelined hits and flush
    drain();
    translation_en_i = 1'b1;
    find_mapped(hot_va);
    flush_tlb();
    access(mmu_pkg::e_load, hot_va, '0);
    for (int i = 0; i < 12; i++) begin
      va      = hot_va;
      va[4:2] = $urandom;
      access(rand_op(), va, $urandom);
    end
    drain();
    flush_tlb();
    access(mmu_pkg::e_load, hot_va, '0);
    drain();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- mmu_lite.f
verilog/mmu_pkg.sv
verilog/data_ram.sv
verilog/dtlb.sv
verilog/page_walker.sv
verilog/mmu_top.sv
dv/mmu_tb.sv
